// File: rtl/vid_pkg.sv
`default_nettype none

package vid_pkg;

    // ========================================
    // video beat layout
    // ========================================

    localparam int COLOR_W = 8; // bits per channel

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } pixel_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } vsync_t;

    // one beat per clk27, pixel on top
    typedef struct packed {
        pixel_t pix;
        vsync_t sync;
    } vid_beat_t;

    // ========================================
    // OSD colors and palette
    // ========================================

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    localparam pixel_t PAL_BLACK  = '{r: 8'h00, g: 8'h00, b: 8'h00};
    localparam pixel_t PAL_BLUE   = '{r: 8'h00, g: 8'h00, b: 8'hff};
    localparam pixel_t PAL_YELLOW = '{r: 8'hff, g: 8'hff, b: 8'h00};
    localparam pixel_t PAL_WHITE  = '{r: 8'hff, g: 8'hff, b: 8'hff};

endpackage

`default_nettype wire

// File: rtl/board_pkg.sv
`default_nettype none

package board_pkg;

    // ========================================
    // controls word seen by the processor
    // ========================================

    localparam int BTN_W = 6; // button field width

    // msb first: rsvd, btn, ir_cnt, ir_code
    typedef struct packed {
        logic [1:0]       rsvd;    // reads as zero
        logic [BTN_W-1:0] btn;
        logic [7:0]       ir_cnt;  // decoded code count
        logic [15:0]      ir_code; // last decoded code
    } ctrl_word_t;

    // ========================================
    // board keys and button layout
    // ========================================

    localparam int KEY_W = 2;

    // key bit positions inside btn
    localparam int BTN_KEY1_IDX = 5;
    localparam int BTN_KEY0_IDX = 3;

    // unused buttons read as released (1)
    localparam logic [BTN_W-1:0] BTN_IDLE = 6'b01_0111;

    // status LED indices
    localparam int LED_FRAMELOCK = 0;
    localparam int LED_IR_IDLE   = 7; // lit while no IR code

endpackage

`default_nettype wire

// File: rtl/board_io_sync.sv
`timescale 1ns/1ps
`default_nettype none

module board_io_sync (
    input  wire                          clk27,
    input  wire                          sys_reset_n,
    input  wire [board_pkg::KEY_W-1:0]   key_i,           // async, active low
    input  wire                          resync_strobe_i, // async
    input  wire                          framelock_i,
    input  wire [15:0]                   ir_code_i,
    input  wire [7:0]                    ir_cnt_i,
    output logic                         strobe_sync_o,
    output board_pkg::ctrl_word_t        controls_o,
    output logic [7:0]                   led_o
);

    logic [board_pkg::KEY_W-1:0] key_meta;
    logic [board_pkg::KEY_W-1:0] key_sync;
    logic                        strobe_meta;
    logic                        strobe_sync;
    logic [board_pkg::BTN_W-1:0] btn;

    // ========================================
    // two-flop synchronizers
    // ========================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            key_meta    <= '1; // keys released
            key_sync    <= '1;
            strobe_meta <= 1'b0;
            strobe_sync <= 1'b0;
        end else begin
            key_meta    <= key_i;
            key_sync    <= key_meta;
            strobe_meta <= resync_strobe_i;
            strobe_sync <= strobe_meta;
        end
    end

    assign strobe_sync_o = strobe_sync; // level only, edge found downstream

    // ========================================
    // button layout and controls word
    // ========================================

    always_comb begin
        btn = board_pkg::BTN_IDLE;
        btn[board_pkg::BTN_KEY1_IDX] = key_sync[1];
        btn[board_pkg::BTN_KEY0_IDX] = key_sync[0];
    end

    // IR fields already in clk27 domain
    assign controls_o = '{
        rsvd:    2'b00,
        btn:     btn,
        ir_cnt:  ir_cnt_i,
        ir_code: ir_code_i
    };

    // static status LEDs
    always_comb begin
        led_o = '0;
        led_o[board_pkg::LED_FRAMELOCK] = framelock_i;
        led_o[board_pkg::LED_IR_IDLE]   = (ir_code_i == 16'h0000);
    end

endmodule

`default_nettype wire

// File: rtl/resync_led.sv
`timescale 1ns/1ps
`default_nettype none

module resync_led #(
    parameter int LED_HOLD_W = 24
) (
    input  wire  clk27,
    input  wire  sys_reset_n,
    input  wire  strobe_sync_i, // already synchronized
    output logic led_o
);

    logic                  strobe_prev;
    logic                  strobe_rise;
    logic [LED_HOLD_W-1:0] hold_ctr;

    assign strobe_rise = strobe_sync_i & ~strobe_prev;

    // ========================================
    // pulse stretcher
    // ========================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            strobe_prev <= 1'b0;
            hold_ctr    <= '0;
        end else begin
            strobe_prev <= strobe_sync_i;
            if (strobe_rise) begin
                hold_ctr <= '1; // restart hold, also mid-pulse
            end else if (hold_ctr != '0) begin
                hold_ctr <= hold_ctr - 1'b1;
            end
        end
    end

    // lit for 2^LED_HOLD_W - 1 cycles per edge
    assign led_o = (hold_ctr != '0);

endmodule

`default_nettype wire

// File: rtl/osd_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module osd_mixer (
    input  wire                     clk27,
    input  wire                     sys_reset_n,
    input  wire vid_pkg::vid_beat_t vid_i,
    input  wire                     osd_enable_i, // same beat as vid_i
    input  wire vid_pkg::osd_color_e osd_color_i,
    output vid_pkg::vid_beat_t      vid_o
);

    vid_pkg::pixel_t    osd_pix;
    vid_pkg::vid_beat_t stage1_d;
    vid_pkg::vid_beat_t stage1_q;

    // ========================================
    // palette lookup
    // ========================================

    always_comb begin
        case (osd_color_i)
            vid_pkg::OSD_BLACK:  osd_pix = vid_pkg::PAL_BLACK;
            vid_pkg::OSD_BLUE:   osd_pix = vid_pkg::PAL_BLUE;
            vid_pkg::OSD_YELLOW: osd_pix = vid_pkg::PAL_YELLOW;
            vid_pkg::OSD_WHITE:  osd_pix = vid_pkg::PAL_WHITE;
            default:             osd_pix = vid_pkg::PAL_BLACK;
        endcase
    end

    // override pixel only, sync untouched
    always_comb begin
        stage1_d.pix  = osd_enable_i ? osd_pix : vid_i.pix;
        stage1_d.sync = vid_i.sync;
    end

    // ========================================
    // two output registers
    // ========================================

    // stage 1: mix decision
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            stage1_q <= '0;
        end else begin
            stage1_q <= stage1_d;
        end
    end

    // stage 2: retime for the output pins
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            vid_o <= '0;
        end else begin
            vid_o <= stage1_q;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vid_out_top.sv
`timescale 1ns/1ps
`default_nettype none

module vid_out_top #(
    parameter int LED_HOLD_W = 24 // resync LED hold counter width
) (
    input  wire                          clk27,
    input  wire                          sys_reset_n,

    // board inputs
    input  wire [board_pkg::KEY_W-1:0]   key_i,
    input  wire                          resync_strobe_i,
    input  wire                          framelock_i,
    input  wire [15:0]                   ir_code_i,
    input  wire [7:0]                    ir_cnt_i,

    // processed video and OSD
    input  wire vid_pkg::vid_beat_t      vid_i,
    input  wire                          osd_enable_i,
    input  wire vid_pkg::osd_color_e     osd_color_i,

    output vid_pkg::vid_beat_t           vid_o,
    output board_pkg::ctrl_word_t        controls_o,
    output logic [7:0]                   led_o,
    output logic                         resync_led_o
);

    logic strobe_sync; // synchronized scaler resync level

    // ========================================
    // board status side
    // ========================================

    board_io_sync u_io (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .key_i           (key_i),
        .resync_strobe_i (resync_strobe_i),
        .framelock_i     (framelock_i),
        .ir_code_i       (ir_code_i),
        .ir_cnt_i        (ir_cnt_i),
        .strobe_sync_o   (strobe_sync),
        .controls_o      (controls_o),
        .led_o           (led_o)
    );

    resync_led #(
        .LED_HOLD_W (LED_HOLD_W)
    ) u_resync (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n),
        .strobe_sync_i (strobe_sync),
        .led_o         (resync_led_o)
    );

    // ========================================
    // video output path
    // ========================================

    osd_mixer u_osd (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .vid_i        (vid_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .vid_o        (vid_o)
    );

endmodule

`default_nettype wire

// File: verif/vid_out_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module vid_out_assertions (
    input wire                        clk27,
    input wire                        sys_reset_n,
    input wire vid_pkg::vid_beat_t    vid_in_i,
    input wire vid_pkg::vid_beat_t    vid_out_i,
    input wire                        resync_led_i,
    input wire board_pkg::ctrl_word_t controls_i
);

    int         reset_fails = 0;
    int         rsvd_fails  = 0;
    int         sync_fails  = 0;
    int         assert_fails;
    logic [1:0] live_cycles; // edges since reset release, saturating

    assign assert_fails = reset_fails + rsvd_fails + sync_fails;

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            live_cycles <= 2'd0;
        end else if (live_cycles != 2'd3) begin
            live_cycles <= live_cycles + 2'd1;
        end
    end

    // ========================================
    // output checks
    // ========================================

    reset_outputs_zero: assert property (
        @(posedge clk27) !sys_reset_n |-> (vid_out_i == '0 && !resync_led_i)
    ) else begin
        reset_fails++;
        $error("vid_o or resync_led_o not zero during reset");
    end

    rsvd_zero: assert property (@(posedge clk27) controls_i.rsvd == 2'b00) else begin
        rsvd_fails++;
        $error("controls_o.rsvd is not zero");
    end

    // sync bits pass the two stages untouched
    sync_delay_two: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        live_cycles[1] |-> (vid_out_i.sync == $past(vid_in_i.sync, 2))
    ) else begin
        sync_fails++;
        $error("vid_o sync bits differ from vid_i two cycles earlier");
    end

endmodule

`default_nettype wire

// File: verif/tb_vid_out_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vid_out_top;

    localparam string STIM_FILE   = "verif/vid_out_stim.txt";
    localparam int    MAX_RECORDS = 64;

    // one expected output beat, chk low for idle cycles
    typedef struct packed {
        logic               chk;
        vid_pkg::vid_beat_t beat;
    } exp_entry_t;

    logic                        clk27;
    logic                        sys_reset_n;
    logic [board_pkg::KEY_W-1:0] key_i;
    logic                        resync_strobe_i;
    logic                        framelock_i;
    logic [15:0]                 ir_code_i;
    logic [7:0]                  ir_cnt_i;
    vid_pkg::vid_beat_t          vid_i;
    logic                        osd_enable_i;
    vid_pkg::osd_color_e         osd_color_i;
    vid_pkg::vid_beat_t          vid_o;
    board_pkg::ctrl_word_t       controls_o;
    logic [7:0]                  led_o;
    logic                        resync_led_o;

    logic [7:0]  rec_kind [MAX_RECORDS];
    logic [31:0] rec_f    [MAX_RECORDS][6];
    int          n_records = 0;
    int          n_checks  = 0;
    int          n_errors  = 0;
    int          n_other   = 0;
    int          total_fail;
    integer      seed;
    exp_entry_t  exp_q [$]; // beats in flight through the mixer

    vid_out_top #(
        .LED_HOLD_W (6)
    ) u_dut (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .key_i           (key_i),
        .resync_strobe_i (resync_strobe_i),
        .framelock_i     (framelock_i),
        .ir_code_i       (ir_code_i),
        .ir_cnt_i        (ir_cnt_i),
        .vid_i           (vid_i),
        .osd_enable_i    (osd_enable_i),
        .osd_color_i     (osd_color_i),
        .vid_o           (vid_o),
        .controls_o      (controls_o),
        .led_o           (led_o),
        .resync_led_o    (resync_led_o)
    );

    bind vid_out_top vid_out_assertions u_assert (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .vid_in_i     (vid_i),
        .vid_out_i    (vid_o),
        .resync_led_i (resync_led_o),
        .controls_i   (controls_o)
    );

    initial clk27 = 1'b0;
    always #5 clk27 = ~clk27; // 10 ns period

    // ========================================
    // helpers
    // ========================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("[FAIL] %s at %0t: expected %h, got %h", name, $time, expected, actual);
        end
    endtask

    // falling edge, compare the beat driven two cycles ago
    task automatic next_cycle(input logic chk, input vid_pkg::vid_beat_t expect_beat);
        exp_entry_t head;
        @(negedge clk27);
        if (exp_q.size() == 2) begin
            head = exp_q.pop_front();
            if (head.chk) begin
                check_value("video beat", 32'(head.beat), 32'(vid_o));
            end
        end
        exp_q.push_back('{chk: chk, beat: expect_beat});
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle(1'b0, '0);
    endtask

    task automatic read_stim();
        int          fd;
        int          code;
        int          nf;
        logic        bad;
        logic [7:0]  letter;
        logic [31:0] f [6];
        logic [8*128-1:0] line_buf;
        bad = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            n_other++;
        end else begin
            code = $fscanf(fd, " %c", letter);
            while (code == 1 && !bad) begin
                if (letter == "#") begin
                    code = $fgets(line_buf, fd); // skip comment line
                end else begin
                    f = '{default: 32'h0};
                    case (letter)
                        "V", "K": begin
                            nf = 6;
                            code = $fscanf(fd, " %h %h %h %h %h %h",
                                           f[0], f[1], f[2], f[3], f[4], f[5]);
                        end
                        "S": begin
                            nf = 4;
                            code = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
                        end
                        "W": begin
                            nf = 1;
                            code = $fscanf(fd, " %h", f[0]);
                        end
                        default: begin
                            nf = -1;
                        end
                    endcase
                    if (code != nf || n_records >= MAX_RECORDS) begin
                        $display("stimulus record %0d is malformed or over the limit", n_records);
                        n_other++;
                        bad = 1'b1;
                    end else begin
                        rec_kind[n_records] = letter;
                        rec_f[n_records]    = f;
                        n_records++;
                    end
                end
                code = $fscanf(fd, " %c", letter);
            end
            $fclose(fd);
        end
    endtask

    // ========================================
    // record players
    // ========================================

    task automatic play_video(input int idx);
        int                 n;
        logic [31:0]        rnd;
        vid_pkg::vid_beat_t beat;
        vid_pkg::vid_beat_t expect_beat;
        n = int'(rec_f[idx][0]);
        for (int k = 0; k < n; k++) begin
            if (n > 1) begin // burst of random beats
                rnd = $random(seed);
                beat.pix  = rnd[23:0];
                beat.sync = rnd[26:24];
            end else begin
                beat.pix  = rec_f[idx][4][23:0];
                beat.sync = rec_f[idx][3][2:0];
            end
            expect_beat.sync = beat.sync;
            expect_beat.pix  = (n > 1 && rec_f[idx][1][0] == 1'b0) ? beat.pix
                                                                    : rec_f[idx][5][23:0];
            next_cycle(1'b1, expect_beat);
            vid_i        = beat;
            osd_enable_i = rec_f[idx][1][0];
            osd_color_i  = vid_pkg::osd_color_e'(rec_f[idx][2][1:0]);
        end
    endtask

    task automatic apply_keys(input int idx);
        next_cycle(1'b0, '0);
        key_i       = rec_f[idx][0][1:0];
        ir_code_i   = rec_f[idx][1][15:0];
        ir_cnt_i    = rec_f[idx][2][7:0];
        framelock_i = rec_f[idx][3][0];
        #1;
        check_value("controls ir_code", 32'(rec_f[idx][1][15:0]), 32'(controls_o.ir_code));
        check_value("controls ir_cnt", 32'(rec_f[idx][2][7:0]), 32'(controls_o.ir_cnt));
        check_value("controls rsvd", 32'h0, 32'(controls_o.rsvd));
        check_value("status leds", 32'(rec_f[idx][5][7:0]), 32'(led_o));
        idle_cycles(2); // key synchronizer depth
        check_value("controls btn", 32'(rec_f[idx][4][5:0]), 32'(controls_o.btn));
    endtask

    task automatic pulse_strobe(input int idx);
        int   hold;
        int   delay;
        int   len;
        int   ticks;
        int   high_len;
        logic chk;
        hold     = int'(rec_f[idx][0]);
        chk      = rec_f[idx][1][0];
        delay    = int'(rec_f[idx][2]);
        len      = int'(rec_f[idx][3]);
        ticks    = 0;
        high_len = 0;
        next_cycle(1'b0, '0);
        resync_strobe_i = 1'b1;
        while (ticks < hold || (chk && ticks < delay)) begin
            next_cycle(1'b0, '0);
            ticks++;
            if (ticks == hold) begin
                resync_strobe_i = 1'b0;
            end
        end
        if (chk) begin
            check_value("resync led on", 32'h1, 32'(resync_led_o));
            while (resync_led_o && high_len <= len + 4) begin
                high_len++;
                next_cycle(1'b0, '0);
            end
            check_value("resync led length", 32'(len), 32'(high_len));
        end
    endtask

    // ========================================
    // main sequence and watchdog
    // ========================================

    initial begin
        seed            = 18;
        sys_reset_n     = 1'b0;
        key_i           = '1; // released
        resync_strobe_i = 1'b0;
        framelock_i     = 1'b0;
        ir_code_i       = 16'h0000;
        ir_cnt_i        = 8'h00;
        vid_i           = '0;
        osd_enable_i    = 1'b0;
        osd_color_i     = vid_pkg::OSD_BLACK;
        read_stim();
        repeat (2) @(negedge clk27);
        sys_reset_n = 1'b1;
        check_value("reset vid_o", 32'h0, 32'(vid_o));
        check_value("reset resync led", 32'h0, 32'(resync_led_o));
        check_value("reset btn", 32'({board_pkg::BTN_W{1'b1}}), 32'(controls_o.btn));
        for (int i = 0; i < n_records; i++) begin
            case (rec_kind[i])
                "V":     play_video(i);
                "K":     apply_keys(i);
                "S":     pulse_strobe(i);
                default: idle_cycles(int'(rec_f[i][0]));
            endcase
        end
        idle_cycles(2); // drain the mixer pipeline
        total_fail = n_errors + n_other + u_dut.u_assert.assert_fails;
        $display("checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
                 n_checks, n_errors, n_other, u_dut.u_assert.assert_fails);
        if (total_fail == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (n_records > 0);
        repeat (n_records * 80 + 200) @(posedge clk27);
        $display("watchdog expired, the test sequence did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/vid_out_stim.txt
# letter then hex fields. V count en color sync pix exp_pix (count above 1 is a random burst)
# K key ir_code ir_cnt framelock exp_btn exp_led, S hold check delay length, W cycles
W 3
V 10 0 0 0 000000 000000
V 1 1 0 7 123456 000000
V 1 1 1 5 abcdef 0000ff
V 1 0 2 1 a5a5a5 a5a5a5
V 1 1 2 2 5a5a5a ffff00
V 1 1 3 4 808080 ffffff
V 1 0 3 3 0f1e2d 0f1e2d
V 1 1 0 6 ffffff 000000
V 1 0 1 1 314159 314159
W 4
K 3 0000 00 0 3f 80
K 2 1234 05 1 37 01
K 1 00ff 7f 0 1f 00
K 0 0000 ff 1 17 81
K 3 beef 01 1 3f 01
S 3 1 3 3f
W 5
S 3 0 3 3f
W e
S 3 1 3 3f
W 4
V 8 1 2 0 000000 ffff00
V 1 0 0 2 c0ffee c0ffee
V 1 1 1 7 c0ffee 0000ff
W 2

// File: build.f
rtl/vid_pkg.sv
rtl/board_pkg.sv
rtl/board_io_sync.sv
rtl/resync_led.sv
rtl/osd_mixer.sv
rtl/vid_out_top.sv
verif/vid_out_assertions.sv
verif/tb_vid_out_top.sv

// File: Makefile
TOP := tb_vid_out_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir
